// ==== feed_pkg.sv ====
// Feed decoder shared constants and the beat word type
package feed_pkg;

  // ------------------------------------------------------------------------
  // Bus geometry
  // ------------------------------------------------------------------------

  // Bytes carried by one streaming beat
  localparam int BEAT_BYTES  = 8;
  // Data bus width in bits
  localparam int DATA_WIDTH  = 64;
  // Width of the empty field, counts 0 to 7 unused bytes
  localparam int EMPTY_WIDTH = 3;
  // Byte pointers into the stream, wide enough for a 32 byte payload plus slack
  localparam int PTR_WIDTH   = 6;

  // ------------------------------------------------------------------------
  // Packet and message format
  // ------------------------------------------------------------------------

  // Message count at the head of every packet
  localparam int MSG_CNT_BYTES = 2;
  // Length field in front of every payload
  localparam int MSG_LEN_BYTES = 2;
  // Legal payload sizes
  localparam int MSG_MIN_BYTES = 8;
  localparam int MSG_MAX_BYTES = 32;
  // First payload byte of a packet sits after count and length
  localparam int MSG_PTR_START = MSG_CNT_BYTES + MSG_LEN_BYTES;

  // One beat, seen either as raw bytes or as a packet header.
  // Byte 0 is the first byte on the wire, bits 63:56
  typedef union packed {
    logic [0:BEAT_BYTES-1][7:0] bytes;
    struct packed {
      // Number of messages in the packet, not checked
      logic [MSG_CNT_BYTES*8-1:0] msg_count;
      // Length of the first message
      logic [MSG_LEN_BYTES*8-1:0] first_len;
      // Leading payload bytes of the first message
      logic [DATA_WIDTH-(MSG_CNT_BYTES+MSG_LEN_BYTES)*8-1:0] lead_payload;
    } hdr;
  } feed_beat_u;

endpackage

// ==== feed_beat_queue.sv ====
// Feed decoder input queue: skid beat plus new and old stages forming 16 bytes
`timescale 1ns/1ps
`default_nettype none

module feed_beat_queue
  import feed_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 reset_n,
  // Input streaming side
  input  wire logic                 in_valid,
  input  wire logic                 in_startofpacket,
  input  wire logic                 in_endofpacket,
  input  wire feed_beat_u           in_data,
  input  wire logic                 in_ready,
  // Control from aligner and tracker
  input  wire logic                 advance,
  input  wire logic                 update_old,
  input  wire logic [PTR_WIDTH-1:0] eom_queue_pos,
  // Queue contents
  output feed_beat_u                new_beat,
  output feed_beat_u                old_beat,
  output logic                      new_valid,
  output logic                      new_sop,
  output logic                      new_eop,
  output logic                      new_som,
  output logic                      old_valid,
  output logic                      old_sop,
  output logic                      old_eop,
  output logic                      old_som
);

  feed_beat_u shadow_beat;
  logic       shadow_valid;
  logic       shadow_sop;
  logic       shadow_eop;
  logic       accept;
  logic       ld_new;
  logic       catch_beat;

  // Bus handshake completes here
  assign accept     = in_valid & in_ready;
  // New stage frees up when empty or moving to the old stage
  assign ld_new     = advance & (~new_valid | update_old);
  // Beat taken from the bus while the new stage is still occupied
  assign catch_beat = accept & ~ld_new;

  // ------------------------------------------------------------------------
  // Shadow stage
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      shadow_valid <= 1'b0;
    end else if (catch_beat) begin
      shadow_valid <= 1'b1;
    end else if (ld_new) begin
      // Drained into the new stage
      shadow_valid <= 1'b0;
    end
  end

  // Payload and flags of the caught beat
  always_ff @(posedge clk) begin
    if (catch_beat) begin
      shadow_beat <= in_data;
      shadow_sop  <= in_startofpacket;
      shadow_eop  <= in_endofpacket;
    end
  end

  // ------------------------------------------------------------------------
  // New and old stages
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      new_valid <= 1'b0;
      new_sop   <= 1'b0;
      new_eop   <= 1'b0;
    end else if (ld_new) begin
      // Shadow first, it is older than anything on the bus
      new_valid <= shadow_valid | accept;
      new_sop   <= shadow_valid ? shadow_sop : in_startofpacket;
      new_eop   <= shadow_valid ? shadow_eop : in_endofpacket;
    end
  end

  always_ff @(posedge clk) begin
    if (ld_new) begin
      new_beat <= shadow_valid ? shadow_beat : in_data;
    end
  end

  // Old stage sits on top of the new stage
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      old_valid <= 1'b0;
      old_sop   <= 1'b0;
      old_eop   <= 1'b0;
      old_som   <= 1'b0;
    end else if (update_old) begin
      old_valid <= new_valid;
      old_sop   <= new_sop;
      old_eop   <= new_eop;
      old_som   <= new_som;
    end
  end

  always_ff @(posedge clk) begin
    if (update_old) begin
      old_beat <= new_beat;
    end
  end

  // Next payload begins in the new beat: a packet start, or the
  // current message ends 5 to 12 bytes below the top of the queue
  assign new_som = new_valid & (new_sop | (eom_queue_pos inside {[5:12]}));

  // Stall from the tracker must block the bus while a beat waits here
  a_shadow_not_overwritten: assert property (
    @(posedge clk) disable iff (!reset_n)
    shadow_valid |-> !accept
  );

endmodule

`default_nettype wire

// ==== feed_msg_tracker.sv ====
// Feed decoder control path computing pointers, next length, stall and load timing
`timescale 1ns/1ps
`default_nettype none

module feed_msg_tracker
  import feed_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   reset_n,
  input  wire logic                   advance,
  // Queue contents
  input  wire feed_beat_u             new_beat,
  input  wire feed_beat_u             old_beat,
  input  wire logic                   new_valid,
  input  wire logic                   new_sop,
  input  wire logic                   new_eop,
  input  wire logic                   new_som,
  input  wire logic                   old_valid,
  input  wire logic                   old_sop,
  input  wire logic                   old_eop,
  input  wire logic                   old_som,
  // Queue and aligner control
  output logic                        update_old,
  output logic [PTR_WIDTH-1:0]        rd_ptr,
  output logic [PTR_WIDTH-1:0]        eom_queue_pos,
  output logic                        msg_valid,
  output logic                        msg_start,
  output logic                        msg_end,
  output logic [EMPTY_WIDTH-1:0]      msg_empty,
  output logic                        stall
);

  logic [PTR_WIDTH-1:0] que_ptr;
  logic [PTR_WIDTH-1:0] eom_ptr;
  logic [PTR_WIDTH-1:0] left;
  logic [PTR_WIDTH-1:0] nxt_rd_ptr;
  logic [15:0]          nxt_len;
  logic [0:2*BEAT_BYTES-1][7:0] q_bytes;
  logic [3:0]           len_idx;
  logic                 hunt;
  logic                 pending;
  logic                 first_beat;
  logic                 eom_in_old;
  logic                 at_eom;
  logic                 pkt_end;
  logic                 load_sop;
  logic                 load_old;
  logic                 load_shift;
  logic                 load_any;
  logic                 dly_shift;
  logic                 go_pending;
  logic                 update_raw;

  // ------------------------------------------------------------------------
  // Pointer math
  // ------------------------------------------------------------------------

  // End of message relative to the top of the old beat
  assign eom_queue_pos = eom_ptr - que_ptr;
  assign eom_in_old    = eom_queue_pos < PTR_WIDTH'(BEAT_BYTES);
  // Bytes left after the read pointer minus one
  assign left          = eom_ptr - rd_ptr;

  // Beat goes out when the bytes it needs are in the queue
  assign msg_valid = ~hunt & ~pending & old_valid & (new_valid | eom_in_old);
  assign msg_start = first_beat;
  assign msg_end   = left < PTR_WIDTH'(BEAT_BYTES);
  assign msg_empty = msg_end ? EMPTY_WIDTH'(BEAT_BYTES - 1) - left[EMPTY_WIDTH-1:0]
                             : '0;

  // Message finished now or earlier and still waiting to load
  assign at_eom  = (msg_valid & msg_end) | pending;
  assign pkt_end = msg_valid & msg_end & (eom_in_old ? old_eop : new_eop);

  // Load cases
  // sop beat in new stage, next payload in the old beat, next payload in new
  assign load_sop   = hunt & new_valid & new_sop;
  assign load_old   = at_eom & ~pkt_end & (eom_queue_pos <= PTR_WIDTH'(4));
  assign load_shift = at_eom & ~pkt_end & ~load_old & new_som;
  assign load_any   = load_sop | load_old | load_shift;
  // Length below the queue bottom needs one shift and a load a cycle later
  assign dly_shift  = msg_valid & msg_end & ~pkt_end & (eom_queue_pos > PTR_WIDTH'(12));
  assign go_pending = at_eom & ~pkt_end & ~load_old & ~load_shift;

  // Outside a packet every beat shifts up whether sop or not
  assign update_raw = hunt ? new_valid
                           : ((msg_valid & ~msg_end) | load_shift | dly_shift);
  assign update_old = update_raw & advance;

  // ------------------------------------------------------------------------
  // Next length extraction
  // ------------------------------------------------------------------------

  // Old beat on top of new beat as 16 bytes
  assign q_bytes = {old_beat.bytes, new_beat.bytes};
  // Length field follows the last payload byte
  assign len_idx = eom_queue_pos[3:0] + 4'd1;

  always_comb begin
    if (load_sop) begin
      nxt_len    = new_beat.hdr.first_len;
      nxt_rd_ptr = PTR_WIDTH'(MSG_PTR_START);
    end else begin
      nxt_len    = {q_bytes[len_idx], q_bytes[len_idx + 4'd1]};
      // Payload follows the length and sits one beat higher after a shift
      if (load_shift) begin
        nxt_rd_ptr = eom_queue_pos - PTR_WIDTH'(BEAT_BYTES - MSG_LEN_BYTES - 1);
      end else begin
        nxt_rd_ptr = eom_queue_pos + PTR_WIDTH'(MSG_LEN_BYTES + 1);
      end
    end
  end

  // ------------------------------------------------------------------------
  // State
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      hunt       <= 1'b1;
      pending    <= 1'b0;
      first_beat <= 1'b0;
      que_ptr    <= '0;
      rd_ptr     <= PTR_WIDTH'(MSG_PTR_START);
      eom_ptr    <= '0;
    end else if (advance) begin
      if (pkt_end) begin
        // Clear out and wait for the next sop
        hunt       <= 1'b1;
        pending    <= 1'b0;
        first_beat <= 1'b0;
        que_ptr    <= '0;
        rd_ptr     <= PTR_WIDTH'(MSG_PTR_START);
        eom_ptr    <= '0;
      end else if (load_any) begin
        hunt       <= 1'b0;
        pending    <= 1'b0;
        first_beat <= 1'b1;
        que_ptr    <= '0;
        rd_ptr     <= nxt_rd_ptr;
        eom_ptr    <= nxt_rd_ptr + nxt_len[PTR_WIDTH-1:0] - PTR_WIDTH'(1);
      end else if (dly_shift) begin
        // Dead cycle on the output while the length moves up
        pending <= 1'b1;
        que_ptr <= que_ptr + PTR_WIDTH'(BEAT_BYTES);
      end else if (go_pending) begin
        pending <= 1'b1;
      end else if (msg_valid) begin
        first_beat <= 1'b0;
        que_ptr    <= que_ptr + PTR_WIDTH'(BEAT_BYTES);
        rd_ptr     <= rd_ptr + PTR_WIDTH'(BEAT_BYTES);
      end
    end
  end

  // Hold the bus when the new stage keeps its beat
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      stall <= 1'b0;
    end else if (advance) begin
      stall <= new_valid & ~update_raw;
    end
  end

  a_len_in_range: assert property (
    @(posedge clk) disable iff (!reset_n)
    (advance && load_any) |-> (nxt_len >= MSG_MIN_BYTES && nxt_len <= MSG_MAX_BYTES)
  );

endmodule

`default_nettype wire

// ==== feed_msg_aligner.sv ====
// Feed decoder output stage aligning queue bytes and registering the streaming controls
`timescale 1ns/1ps
`default_nettype none

module feed_msg_aligner
  import feed_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   reset_n,
  input  wire logic                   out_ready,
  // Queue bytes and read position
  input  wire feed_beat_u             old_beat,
  input  wire feed_beat_u             new_beat,
  input  wire logic [PTR_WIDTH-1:0]   rd_ptr,
  // Next beat description from the tracker
  input  wire logic                   msg_valid,
  input  wire logic                   msg_start,
  input  wire logic                   msg_end,
  input  wire logic [EMPTY_WIDTH-1:0] msg_empty,
  // Output streaming side
  output logic                        out_valid,
  output logic                        out_startofpacket,
  output logic                        out_endofpacket,
  output logic [DATA_WIDTH-1:0]       out_data,
  output logic [EMPTY_WIDTH-1:0]      out_empty,
  output logic                        advance
);

  logic [2*DATA_WIDTH-1:0] queue_word;
  logic [2*DATA_WIDTH-1:0] shifted;
  feed_beat_u              aligned;

  // Output register free to load
  assign advance = ~out_valid | out_ready;

  // ------------------------------------------------------------------------
  // Byte select
  // ------------------------------------------------------------------------

  assign queue_word = {old_beat, new_beat};
  // Read position moves to the top
  assign shifted    = queue_word << (8 * rd_ptr[EMPTY_WIDTH-1:0]);

  always_comb begin
    aligned = shifted[2*DATA_WIDTH-1 -: DATA_WIDTH];
    // Bytes past the end of message go out as zero
    for (int i = 0; i < BEAT_BYTES; i++) begin
      if (msg_end && (i + int'(msg_empty) >= BEAT_BYTES)) begin
        aligned.bytes[i] = 8'h00;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      out_valid         <= 1'b0;
      out_startofpacket <= 1'b0;
      out_endofpacket   <= 1'b0;
      out_empty         <= '0;
    end else if (advance) begin
      out_valid         <= msg_valid;
      out_startofpacket <= msg_valid & msg_start;
      out_endofpacket   <= msg_valid & msg_end;
      out_empty         <= msg_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      out_data <= aligned;
    end
  end

endmodule

`default_nettype wire

// ==== feed_decoder.sv ====
// Feed decoder top: splits packet messages into individual streaming packets
`timescale 1ns/1ps
`default_nettype none

module feed_decoder
  import feed_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   reset_n,
  // Input packet stream
  input  wire logic                   in_valid,
  output logic                        in_ready,
  input  wire logic                   in_startofpacket,
  input  wire logic                   in_endofpacket,
  input  wire logic [DATA_WIDTH-1:0]  in_data,
  // Output message stream
  output logic                        out_valid,
  input  wire logic                   out_ready,
  output logic                        out_startofpacket,
  output logic                        out_endofpacket,
  output logic [DATA_WIDTH-1:0]       out_data,
  output logic [EMPTY_WIDTH-1:0]      out_empty
);

  feed_beat_u           new_beat;
  feed_beat_u           old_beat;
  logic                 new_valid, new_sop, new_eop, new_som;
  logic                 old_valid, old_sop, old_eop, old_som;
  logic                 advance;
  logic                 update_old;
  logic                 stall;
  logic                 msg_valid, msg_start, msg_end;
  logic [EMPTY_WIDTH-1:0] msg_empty;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH-1:0] eom_queue_pos;

  // Output back-pressure, plus realign stalls
  assign in_ready = out_ready & ~stall;

  feed_beat_queue i_feed_beat_queue (
    .clk, .reset_n,
    .in_valid, .in_startofpacket, .in_endofpacket,
    .in_data          (feed_beat_u'(in_data)),
    .in_ready, .advance, .update_old, .eom_queue_pos,
    .new_beat, .old_beat,
    .new_valid, .new_sop, .new_eop, .new_som,
    .old_valid, .old_sop, .old_eop, .old_som
  );

  feed_msg_tracker i_feed_msg_tracker (
    .clk, .reset_n, .advance,
    .new_beat, .old_beat,
    .new_valid, .new_sop, .new_eop, .new_som,
    .old_valid, .old_sop, .old_eop, .old_som,
    .update_old, .rd_ptr, .eom_queue_pos,
    .msg_valid, .msg_start, .msg_end, .msg_empty,
    .stall
  );

  // Registered output stage, also the source of advance
  feed_msg_aligner i_feed_msg_aligner (
    .clk, .reset_n, .out_ready,
    .old_beat, .new_beat, .rd_ptr,
    .msg_valid, .msg_start, .msg_end, .msg_empty,
    .out_valid, .out_startofpacket, .out_endofpacket,
    .out_data, .out_empty,
    .advance
  );

endmodule

`default_nettype wire

// ==== tb_feed_decoder.sv ====
// Feed decoder testbench driving random packets against a reference model with a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_feed_decoder
  import feed_pkg::*;
();

  localparam int CLK_PERIOD        = 4;
  localparam int RESET_CYCLES      = 10;
  localparam int WATCHDOG_PER_BEAT = 200;
  localparam int RANDOM_PACKETS    = 40;

  typedef logic [7:0] byte_q_t[$];
  typedef int         len_q_t[$];

  logic                   clk;
  logic                   reset_n;
  logic                   in_valid;
  logic                   in_ready;
  logic                   in_startofpacket;
  logic                   in_endofpacket;
  feed_beat_u             in_data;
  logic                   out_valid;
  logic                   out_ready;
  logic                   out_startofpacket;
  logic                   out_endofpacket;
  logic [DATA_WIDTH-1:0]  out_data;
  logic [EMPTY_WIDTH-1:0] out_empty;

  // Input beats to send, all built before reset ends
  feed_beat_u             stim_data[$];
  bit                     stim_sop[$];
  bit                     stim_eop[$];
  // Expected output beats from the reference function
  feed_beat_u             exp_data[$];
  bit                     exp_sop[$];
  bit                     exp_eop[$];
  logic [EMPTY_WIDTH-1:0] exp_empty[$];

  // Output beat seen under back-pressure
  feed_beat_u             held_data;
  bit                     held_sop;
  bit                     held_eop;
  logic [EMPTY_WIDTH-1:0] held_empty;
  bit                     held;

  logic [31:0] gen_rnd;
  logic [31:0] bp_rnd;
  bit          bp_on;
  bit          gen_done;
  int          bp_start_beat;
  int          watchdog_cycles;
  int          checked_beats;

  feed_decoder i_feed_decoder (
    .clk, .reset_n,
    .in_valid, .in_ready, .in_startofpacket, .in_endofpacket,
    .in_data,
    .out_valid, .out_ready, .out_startofpacket, .out_endofpacket,
    .out_data, .out_empty
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------

  // Walks the packet bytes past the count and splits each payload into beats
  function automatic void build_expected(input byte_q_t pkt);
    int         pos;
    int         len;
    int         nbeats;
    int         idx;
    feed_beat_u beat;
    pos = MSG_CNT_BYTES;
    while (pos + MSG_LEN_BYTES <= pkt.size()) begin
      len    = int'({pkt[pos], pkt[pos+1]});
      pos    = pos + MSG_LEN_BYTES;
      nbeats = (len + BEAT_BYTES - 1) / BEAT_BYTES;
      for (int b = 0; b < nbeats; b++) begin
        beat = '0;
        for (int k = 0; k < BEAT_BYTES; k++) begin
          idx = b * BEAT_BYTES + k;
          // Bytes past the payload stay zero
          if (idx < len) begin
            beat.bytes[k] = pkt[pos + idx];
          end
        end
        exp_data.push_back(beat);
        exp_sop.push_back(b == 0);
        exp_eop.push_back(b == nbeats - 1);
        if (b == nbeats - 1) begin
          exp_empty.push_back(EMPTY_WIDTH'((BEAT_BYTES - (len - b * BEAT_BYTES)) % BEAT_BYTES));
        end else begin
          exp_empty.push_back('0);
        end
      end
      pos = pos + len;
    end
  endfunction

  // Builds one packet from a list of payload lengths and queues its beats
  task automatic gen_packet(input len_q_t lens);
    byte_q_t    pkt;
    feed_beat_u beat;
    int         nbeats;
    pkt.push_back(8'(lens.size() >> 8));
    pkt.push_back(8'(lens.size()));
    foreach (lens[m]) begin
      pkt.push_back(8'(lens[m] >> 8));
      pkt.push_back(8'(lens[m]));
      for (int i = 0; i < lens[m]; i++) begin
        gen_rnd = lcg_step(gen_rnd);
        pkt.push_back(gen_rnd[23:16]);
      end
    end
    build_expected(pkt);
    // First byte of each beat in bits 63:56 with zero fill after the last message
    nbeats = (pkt.size() + BEAT_BYTES - 1) / BEAT_BYTES;
    for (int b = 0; b < nbeats; b++) begin
      beat = '0;
      for (int k = 0; k < BEAT_BYTES; k++) begin
        if (b * BEAT_BYTES + k < pkt.size()) begin
          beat.bytes[k] = pkt[b * BEAT_BYTES + k];
        end
      end
      stim_data.push_back(beat);
      stim_sop.push_back(b == 0);
      stim_eop.push_back(b == nbeats - 1);
    end
  endtask

  task automatic gen_random_packet();
    len_q_t lens;
    int     n;
    gen_rnd = lcg_step(gen_rnd);
    n = 1 + int'(gen_rnd[30:16]) % 6;
    for (int m = 0; m < n; m++) begin
      gen_rnd = lcg_step(gen_rnd);
      lens.push_back(MSG_MIN_BYTES + int'(gen_rnd[30:16]) % (MSG_MAX_BYTES - MSG_MIN_BYTES + 1));
    end
    gen_packet(lens);
  endtask

  // ------------------------------------------------------------------------
  // Driving and checking
  // ------------------------------------------------------------------------

  // Holds the beat from the falling edge until in_ready is seen
  task automatic send_beat(input feed_beat_u data, input bit sop, input bit eop);
    bit taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      in_valid         = 1'b1;
      in_data          = data;
      in_startofpacket = sop;
      in_endofpacket   = eop;
      #1;
      taken = in_ready;
    end
  endtask

  task automatic check_data(input feed_beat_u got, input feed_beat_u exp, input int beat_no);
    if (got !== exp) begin
      $display("ERR %0t: beat %0d data %h, expected %h", $time, beat_no, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "Output data mismatch");
    end
  endtask

  task automatic check_flag(input bit got, input bit exp, input string name, input int beat_no);
    if (got !== exp) begin
      $display("ERR %0t: beat %0d %s is %0b, expected %0b", $time, beat_no, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "Output flag mismatch");
    end
  endtask

  task automatic check_empty(input logic [EMPTY_WIDTH-1:0] got,
                             input logic [EMPTY_WIDTH-1:0] exp, input int beat_no);
    if (got !== exp) begin
      $display("ERR %0t: beat %0d empty %0d, expected %0d", $time, beat_no, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "Output empty mismatch");
    end
  endtask

  // Compares each output beat one step after the falling edge
  initial begin
    checked_beats = 0;
    held          = 1'b0;
    forever begin
      @(negedge clk);
      #1;
      // A beat refused on the last edge must still be offered unchanged
      if (held) begin
        check_flag(out_valid, 1'b1, "valid after back-pressure", checked_beats);
        check_data(feed_beat_u'(out_data), held_data, checked_beats);
        check_flag(out_startofpacket, held_sop, "held startofpacket", checked_beats);
        check_flag(out_endofpacket, held_eop, "held endofpacket", checked_beats);
        check_empty(out_empty, held_empty, checked_beats);
      end
      held = reset_n && out_valid && !out_ready;
      if (held) begin
        held_data  = feed_beat_u'(out_data);
        held_sop   = out_startofpacket;
        held_eop   = out_endofpacket;
        held_empty = out_empty;
      end
      if (reset_n && out_valid && out_ready) begin
        if (exp_data.size() == 0) begin
          $display("Decoder sent an output beat that no input message accounts for");
          $display("TESTS FAILED");
          $fatal(1, "Unexpected output beat");
        end else begin
          check_data(feed_beat_u'(out_data), exp_data.pop_front(), checked_beats);
          check_flag(out_startofpacket, exp_sop.pop_front(), "startofpacket", checked_beats);
          check_flag(out_endofpacket, exp_eop.pop_front(), "endofpacket", checked_beats);
          check_empty(out_empty, exp_empty.pop_front(), checked_beats);
          checked_beats++;
        end
      end
    end
  end

  // Output back-pressure with random low periods once enabled
  initial begin
    out_ready = 1'b0;
    forever begin
      @(negedge clk);
      if (!reset_n) begin
        out_ready = 1'b0;
      end else if (bp_on) begin
        bp_rnd    = lcg_step(bp_rnd);
        out_ready = (bp_rnd[17:16] != 2'b00);
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  // Watchdog sized from the number of generated beats
  initial begin
    wait (gen_done);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog timeout: decoder stopped producing output after %0d cycles",
             watchdog_cycles);
    $display("TESTS FAILED");
    $fatal(1, "Watchdog timeout");
  end

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------

  initial begin
    len_q_t lens;
    reset_n          = 1'b0;
    in_valid         = 1'b0;
    in_startofpacket = 1'b0;
    in_endofpacket   = 1'b0;
    in_data          = '0;
    gen_rnd          = 32'd24;
    bp_rnd           = 32'd24;
    bp_on            = 1'b0;
    gen_done         = 1'b0;

    // Single 8 byte message
    lens = {8};
    gen_packet(lens);
    // Every length from 8 to 32 in packets of five messages
    for (int g = 0; g < 5; g++) begin
      lens.delete();
      for (int j = 0; j < 5; j++) begin
        lens.push_back(MSG_MIN_BYTES + g * 5 + j);
      end
      gen_packet(lens);
    end
    // Random packets run with gaps and back-pressure
    bp_start_beat = stim_data.size();
    repeat (RANDOM_PACKETS) gen_random_packet();
    watchdog_cycles = WATCHDOG_PER_BEAT * stim_data.size();
    gen_done        = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    for (int i = 0; i < stim_data.size(); i++) begin
      if (i >= bp_start_beat) begin
        bp_on   = 1'b1;
        gen_rnd = lcg_step(gen_rnd);
        // Idle gap on the input now and then
        if (gen_rnd[17:16] == 2'b00) begin
          repeat (1 + int'(gen_rnd[19:18])) begin
            @(negedge clk);
            in_valid = 1'b0;
          end
        end
      end
      send_beat(stim_data[i], stim_sop[i], stim_eop[i]);
    end
    @(negedge clk);
    in_valid         = 1'b0;
    in_startofpacket = 1'b0;
    in_endofpacket   = 1'b0;

    while (exp_data.size() != 0) @(posedge clk);
    // Room for any stray extra beat to show up
    repeat (20) @(negedge clk);
    if (!out_valid) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("Decoder still offers an output beat after the last expected one");
      $display("TESTS FAILED");
      $fatal(1, "Extra output beat");
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
feed_pkg.sv
feed_beat_queue.sv
feed_msg_tracker.sv
feed_msg_aligner.sv
feed_decoder.sv
tb_feed_decoder.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the feed decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=obj_dir/sim_feed_decoder

echo "Building with Verilator"
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_feed_decoder \
  -f compile.f \
  -Mdir obj_dir -o sim_feed_decoder > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status, see $BUILD_LOG"
  exit 1
fi

if [ ! -x "$SIM_BIN" ]; then
  echo "Simulation binary $SIM_BIN is missing"
  exit 1
fi

echo "Running simulation"
"$SIM_BIN" > "$SIM_LOG" 2>&1
status=$?
tail -n 5 "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status, see $SIM_LOG"
  exit 1
fi

if grep -q "TESTS PASSED" "$SIM_LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $SIM_LOG"
  exit 1
fi
